// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = rv_core_tb
FILELIST  = rv_core.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== design/rv_alu.sv ====
// RV32I integer ALU, combinational.
// Shift amounts come from op_b[4:0]; compares return 0 or 1.

module rv_alu import rv_pkg::*; (
  input  alu_fn_e alu_fn,
  input  word_t   op_a,
  input  word_t   op_b,
  output word_t   result,
  output logic    zero
);

  logic [4:0] shamt;

  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_fn)
      ADD:     result = op_a + op_b;
      SUB:     result = op_a - op_b;
      SLL:     result = op_a << shamt;
      SLT:     result = {31'b0, $signed(op_a) < $signed(op_b)};
      SLTU:    result = {31'b0, op_a < op_b};
      XOR:     result = op_a ^ op_b;
      SRL:     result = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      SRA:     result = word_t'($signed(op_a) >>> shamt);
      OR:      result = op_a | op_b;
      AND:     result = op_a & op_b;
      default: result = '0;
    endcase
  end

  // Used for BEQ and BNE
  assign zero = (result == '0);

endmodule

// ==== design/rv_control.sv ====
// Instruction decoder for the RV32I subset, purely combinational.
// Unknown opcodes select PC_HOLD and disable both writes, stalling the core.

module rv_control import rv_pkg::*; (
  input  inst_fields_t inst_fields,
  input  logic         alu_zero,
  input  logic         alu_lsb,
  output ctrl_t        ctrl
);

  alu_fn_e arith_fn;
  logic    is_op;
  logic    branch_taken;

  assign is_op = (inst_fields.opcode == OPC_OP);

  // funct7[5] selects SUB only for register ops; ADDI has immediate bits there
  always_comb begin
    case (inst_fields.funct3)
      3'b000:  arith_fn = (is_op && inst_fields.funct7[5]) ? SUB : ADD;
      3'b001:  arith_fn = SLL;
      3'b010:  arith_fn = SLT;
      3'b011:  arith_fn = SLTU;
      3'b100:  arith_fn = XOR;
      3'b101:  arith_fn = inst_fields.funct7[5] ? SRA : SRL;
      3'b110:  arith_fn = OR;
      default: arith_fn = AND;
    endcase
  end

  // BEQ/BNE look at zero, the rest at the compare bit; funct3[0] negates
  assign branch_taken = (inst_fields.funct3[2] ? alu_lsb : alu_zero) ^ inst_fields.funct3[0];

  always_comb begin
    ctrl.alu_fn      = ADD;
    ctrl.op_a_pc     = 1'b0;
    ctrl.op_b_imm    = 1'b0;
    ctrl.next_pc_sel = PC_PLUS4;
    ctrl.wb_sel      = WB_ALU;
    ctrl.reg_we      = 1'b0;
    ctrl.mem_we      = 1'b0;
    case (inst_fields.opcode)
      OPC_LUI: begin
        ctrl.wb_sel = WB_IMM;
        ctrl.reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.op_a_pc  = 1'b1;
        ctrl.op_b_imm = 1'b1;
        ctrl.reg_we   = 1'b1;
      end
      OPC_JAL: begin
        ctrl.next_pc_sel = PC_PLUS_IMM;
        ctrl.wb_sel      = WB_PC4;
        ctrl.reg_we      = 1'b1;
      end
      OPC_JALR: begin
        ctrl.op_b_imm    = 1'b1;
        ctrl.next_pc_sel = PC_ALU;
        ctrl.wb_sel      = WB_PC4;
        ctrl.reg_we      = 1'b1;
      end
      OPC_BRANCH: begin
        case (inst_fields.funct3[2:1])
          2'b00:   ctrl.alu_fn = SUB;
          2'b10:   ctrl.alu_fn = SLT;
          2'b11:   ctrl.alu_fn = SLTU;
          default: ctrl.alu_fn = SUB;
        endcase
        if (inst_fields.funct3[2:1] == 2'b01) begin
          ctrl.next_pc_sel = PC_HOLD;
        end else if (branch_taken) begin
          ctrl.next_pc_sel = PC_PLUS_IMM;
        end
      end
      OPC_LOAD: begin
        ctrl.op_b_imm = 1'b1;
        ctrl.wb_sel   = WB_MEM;
        ctrl.reg_we   = 1'b1;
      end
      OPC_STORE: begin
        ctrl.op_b_imm = 1'b1;
        ctrl.mem_we   = 1'b1;
      end
      OPC_OP_IMM, OPC_OP: begin
        ctrl.alu_fn   = arith_fn;
        ctrl.op_b_imm = !is_op;
        ctrl.reg_we   = 1'b1;
      end
      default: ctrl.next_pc_sel = PC_HOLD;
    endcase
    // Stores write memory only, never the register file
    if (inst_fields.opcode == OPC_STORE) begin
      assert (!ctrl.reg_we) else $error("store decoded with reg_we set");
    end
  end

endmodule

// ==== design/rv_core.sv ====
// RV32I single-cycle core, top level.
// Instruction and data memories are external and must answer in the same cycle.
// data_we is a plain level, held low until the first edge after reset release.
// Only word loads and stores are supported.

module rv_core import rv_pkg::*; (
  input  logic  clock,
  input  logic  rst_n,
  output word_t inst_addr,
  input  word_t inst,
  output word_t data_addr,
  output word_t data_wdata,
  output logic  data_we,
  input  word_t data_rdata
);

  inst_fields_t inst_fields;
  ctrl_t        ctrl;
  logic         alu_zero;
  logic         alu_lsb;
  logic         started;

  rv_control u_control (
    .inst_fields(inst_fields),
    .alu_zero   (alu_zero),
    .alu_lsb    (alu_lsb),
    .ctrl       (ctrl)
  );

  // Store address is the ALU sum, store data is rs2
  rv_datapath u_datapath (
    .clock      (clock),
    .rst_n      (rst_n),
    .inst       (inst),
    .data_rdata (data_rdata),
    .ctrl       (ctrl),
    .inst_fields(inst_fields),
    .alu_zero   (alu_zero),
    .alu_lsb    (alu_lsb),
    .pc         (inst_addr),
    .alu_result (data_addr),
    .rs2_data   (data_wdata)
  );

  // Low through reset and until the first edge after release
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  assign data_we = ctrl.mem_we & started;

endmodule

// ==== design/rv_datapath.sv ====
// Single-cycle data path: decode fields, operands, PC and write-back.
// The PC advances on every edge; PC_HOLD keeps it until the next reset.

`include "rv_params.svh"

module rv_datapath import rv_pkg::*; (
  input  logic         clock,
  input  logic         rst_n,
  input  word_t        inst,
  input  word_t        data_rdata,
  input  ctrl_t        ctrl,
  output inst_fields_t inst_fields,
  output logic         alu_zero,
  output logic         alu_lsb,
  output word_t        pc,
  output word_t        alu_result,
  output word_t        rs2_data
);

  word_t imm;
  word_t rs1_data;
  word_t op_a;
  word_t op_b;
  word_t pc_plus4;
  word_t pc_plus_imm;
  word_t next_pc;
  word_t wb_data;

  //--------------------------------------------------------------------
  // Decode
  //--------------------------------------------------------------------
  assign inst_fields = '{opcode: inst[6:0], funct3: inst[14:12], funct7: inst[31:25]};

  rv_imm_gen u_imm (.inst(inst), .imm(imm));

  rv_regfile u_regs (
    .clock   (clock),
    .rs1_addr(inst[19:15]),
    .rs2_addr(inst[24:20]),
    .rd_addr (inst[11:7]),
    .rd_data (wb_data),
    .we      (ctrl.reg_we),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  //--------------------------------------------------------------------
  // Execute
  //--------------------------------------------------------------------
  assign op_a = ctrl.op_a_pc  ? pc  : rs1_data;
  assign op_b = ctrl.op_b_imm ? imm : rs2_data;

  rv_alu u_alu (
    .alu_fn(ctrl.alu_fn),
    .op_a  (op_a),
    .op_b  (op_b),
    .result(alu_result),
    .zero  (alu_zero)
  );

  // Compare result of SLT/SLTU
  assign alu_lsb = alu_result[0];

  //--------------------------------------------------------------------
  // PC and write-back
  //--------------------------------------------------------------------
  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + imm;

  always_comb begin
    case (ctrl.next_pc_sel)
      PC_PLUS4:    next_pc = pc_plus4;
      PC_PLUS_IMM: next_pc = pc_plus_imm;
      PC_ALU:      next_pc = {alu_result[31:1], 1'b0};
      default:     next_pc = pc;
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_ALU:  wb_data = alu_result;
      WB_MEM:  wb_data = data_rdata;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = imm;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // Fetch address stays word aligned out of reset
  a_pc_aligned: assert property (@(posedge clock) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// ==== design/rv_imm_gen.sv ====
// Immediate generator for the supported RV32I formats.
// OP and unknown opcodes give a zero immediate.

module rv_imm_gen import rv_pkg::*; (
  input  word_t inst,
  output word_t imm
);

  always_comb begin
    case (inst[6:0])
      // I-type
      OPC_OP_IMM, OPC_LOAD, OPC_JALR:
        imm = {{20{inst[31]}}, inst[31:20]};
      // S-type
      OPC_STORE:
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      // B-type, bit 0 always clear
      OPC_BRANCH:
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      // U-type
      OPC_LUI, OPC_AUIPC:
        imm = {inst[31:12], 12'b0};
      // J-type
      OPC_JAL:
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

// ==== design/rv_pkg.sv ====
// Types shared by the RV32I core.
// Only the opcodes of the supported subset are listed.

`include "rv_params.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]              word_t;
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  // Major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } alu_fn_e;

  typedef enum logic [1:0] {PC_PLUS4, PC_PLUS_IMM, PC_ALU, PC_HOLD} next_pc_sel_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wb_sel_e;

  // Control word from the decoder to the data path
  typedef struct packed {
    alu_fn_e      alu_fn;
    logic         op_a_pc;
    logic         op_b_imm;
    next_pc_sel_e next_pc_sel;
    wb_sel_e      wb_sel;
    logic         reg_we;
    logic         mem_we;
  } ctrl_t;

  typedef struct packed {
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
  } inst_fields_t;

endpackage

// ==== design/rv_regfile.sv ====
// Integer register file, two combinational reads and one clocked write.
// x0 reads as zero and ignores writes; contents are undefined after reset.

`include "rv_params.svh"

module rv_regfile import rv_pkg::*; (
  input  logic      clock,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  word_t     rd_data,
  input  logic      we,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [`RV_NUM_REGS];

  //--------------------------------------------------------------------
  // Write port
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  //--------------------------------------------------------------------
  // Read ports
  //--------------------------------------------------------------------
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== include/rv_params.svh ====
// Architectural constants for the RV32I core.
// Widths are fixed by the ISA, so these are not meant to be overridden.

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Address the PC takes while reset is held
`define RV_RESET_PC 32'h0000_0000

// Data and address width
`define RV_XLEN 32

// Integer register count, x0 included
`define RV_NUM_REGS 32

`endif

// ==== rv_core.f ====
+incdir+include
design/rv_pkg.sv
design/rv_control.sv
design/rv_imm_gen.sv
design/rv_alu.sv
design/rv_regfile.sv
design/rv_datapath.sv
design/rv_core.sv
verif/rv_core_tb.sv

// ==== verif/rv_core_stimulus.txt ====
// inst  load_data  exp_inst_addr  exp_data_we  exp_data_addr  exp_data_wdata
// load_data applies to LW lines; data_addr and data_wdata are checked when data_we is 1
00500093 00000000 00000000 0 00000000 00000000 // addi x1, x0, 5
FFD00113 00000000 00000004 0 00000000 00000000 // addi x2, x0, -3
402081B3 00000000 00000008 0 00000000 00000000 // sub  x3, x1, x2
10302023 00000000 0000000C 1 00000100 00000008 // sw   x3, 0x100(x0)
0020B2B3 00000000 00000010 0 00000000 00000000 // sltu x5, x1, x2
40515233 00000000 00000014 0 00000000 00000000 // sra  x4, x2, x5
10402223 00000000 00000018 1 00000104 FFFFFFFE // sw   x4, 0x104(x0)
12345337 00000000 0000001C 0 00000000 00000000 // lui  x6, 0x12345
00001397 00000000 00000020 0 00000000 00000000 // auipc x7, 0x1
00730433 00000000 00000024 0 00000000 00000000 // add  x8, x6, x7
10802423 00000000 00000028 1 00000108 12346020 // sw   x8, 0x108(x0)
20002483 CAFEF00D 0000002C 0 00000000 00000000 // lw   x9, 0x200(x0)
10902623 00000000 00000030 1 0000010C CAFEF00D // sw   x9, 0x10c(x0)
00108463 00000000 00000034 0 00000000 00000000 // beq  x1, x1, +8 taken
00208463 00000000 0000003C 0 00000000 00000000 // beq  x1, x2, +8 not taken
00209463 00000000 00000040 0 00000000 00000000 // bne  x1, x2, +8 taken
00109463 00000000 00000048 0 00000000 00000000 // bne  x1, x1, +8 not taken
00114463 00000000 0000004C 0 00000000 00000000 // blt  x2, x1, +8 taken
0020C463 00000000 00000054 0 00000000 00000000 // blt  x1, x2, +8 not taken
00117463 00000000 00000058 0 00000000 00000000 // bgeu x2, x1, +8 taken
0020F463 00000000 00000060 0 00000000 00000000 // bgeu x1, x2, +8 not taken
0080056F 00000000 00000064 0 00000000 00000000 // jal  x10, +8
011505E7 00000000 0000006C 0 00000000 00000000 // jalr x11, 0x11(x10)
10B02823 00000000 00000078 1 00000110 00000070 // sw   x11, 0x110(x0)
00700013 00000000 0000007C 0 00000000 00000000 // addi x0, x0, 7
10002A23 00000000 00000080 1 00000114 00000000 // sw   x0, 0x114(x0)
0000000B 00000000 00000084 0 00000000 00000000 // unknown opcode
0000000B 00000000 00000084 0 00000000 00000000 // stalled
0000000B 00000000 00000084 0 00000000 00000000 // stalled

// ==== verif/rv_core_tb.sv ====
// Testbench for the single-cycle RV32I core, acting as both memories.
// Each stimulus line is one retired instruction; load data is used on LW lines only.
// Expected bus values come from the hand-assembled program in the stimulus file.

`include "rv_params.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int MAX_LINES = 64;
  localparam int FIELDS    = 6;
  localparam int PERIOD    = 20;

  // sw x0, 0x100(x0), presented on inst while reset is held
  localparam word_t RESET_STORE = 32'h1000_2023;

  logic  clock;
  logic  rst_n;
  word_t inst;
  word_t inst_addr;
  word_t data_addr;
  word_t data_wdata;
  logic  data_we;
  word_t data_rdata;

  word_t stim [MAX_LINES*FIELDS];
  int    num_lines;
  int    seed;
  bit    loaded;

  rv_core UUT (
    .clock     (clock),
    .rst_n     (rst_n),
    .inst_addr (inst_addr),
    .inst      (inst),
    .data_addr (data_addr),
    .data_wdata(data_wdata),
    .data_we   (data_we),
    .data_rdata(data_rdata)
  );

  always #(PERIOD/2) clock = ~clock;

  //----------------------------------------------------------------------
  // Helpers
  //----------------------------------------------------------------------
  // Marks words that $readmemh did not overwrite
  function automatic word_t unused_word(input int idx);
    return 32'hBAD0_0000 ^ word_t'(idx);
  endfunction

  function automatic int count_lines();
    int n;
    n = 0;
    while (n < MAX_LINES && stim[n*FIELDS] != unused_word(n*FIELDS)) begin
      n++;
    end
    return n;
  endfunction

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    assert (actual === expected) else begin
      $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Memory model: the load word only on LW, noise otherwise
  task automatic drive_line(input int n);
    word_t instr;
    instr = stim[n*FIELDS];
    inst <= instr;
    if (instr[6:0] == OPC_LOAD) begin
      data_rdata <= stim[n*FIELDS+1];
    end else begin
      data_rdata <= $random(seed);
    end
  endtask

  task automatic check_line(input int n);
    word_t exp_we;
    exp_we = stim[n*FIELDS+3];
    check_value("inst_addr", inst_addr, stim[n*FIELDS+2]);
    check_value("data_we", word_t'(data_we), exp_we);
    if (exp_we != '0) begin
      check_value("data_addr", data_addr, stim[n*FIELDS+4]);
      check_value("data_wdata", data_wdata, stim[n*FIELDS+5]);
    end
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial begin
    clock = 1'b0;
    rst_n <= 1'b0;
    inst <= RESET_STORE;
    data_rdata <= '0;
    seed = 32'hb58a;
    for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
      stim[i] = unused_word(i);
    end
    $readmemh("verif/rv_core_stimulus.txt", stim);
    num_lines = count_lines();
    if (num_lines == 0) begin
      $display("Stimulus file verif/rv_core_stimulus.txt has no usable lines");
      $display("Test failed");
      $fatal(1, "no stimulus");
    end
    loaded = 1'b1;
    // Reset covers the edges at 10, 30 and 50; release lands on the third
    repeat (2) begin
      @(negedge clock);
      check_value("inst_addr", inst_addr, `RV_RESET_PC);
      check_value("data_we", word_t'(data_we), '0);
    end
    for (int n = 0; n < num_lines; n++) begin
      @(posedge clock);
      rst_n <= 1'b1;
      drive_line(n);
      @(negedge clock);
      check_line(n);
    end
    $display("Test completed successfully");
    $finish;
  end

  // Watchdog, sized from the stimulus length plus reset margin
  initial begin
    wait (loaded);
    #((num_lines + 10) * PERIOD);
    $display("Simulation did not finish within %0d clock cycles", num_lines + 10);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule
